// ==== list.f ====
+incdir+include
src/rx_line_pkg.sv
src/xgmii_pkg.sv
src/rx_lane_capture.sv
src/rx_descrambler.sv
src/rx_block_decoder.sv
src/pcs_rx_top.sv
tb/tb_pcs_rx.sv

// ==== Bender.yml ====
package:
  name: pcs_rx

sources:
  - src/rx_line_pkg.sv
  - src/xgmii_pkg.sv
  - src/rx_lane_capture.sv
  - src/rx_descrambler.sv
  - src/rx_block_decoder.sv
  - src/pcs_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_pcs_rx.sv

// ==== include/pcs_rx_model.svh ====
// Reference model of the receive PCS; include inside the testbench module body
`ifndef PCS_RX_MODEL_SVH
`define PCS_RX_MODEL_SVH

localparam int MDL_LANES = rx_line_pkg::NUM_LANES_DEF;

// Scrambler history with bit 57 newest
logic [rx_line_pkg::SCR_TAP_B-1:0] mdl_scr_hist;
xgmii_pkg::xgmii_lane_t            mdl_exp_q [$];
xgmii_pkg::err_cnt_t               mdl_err_cnt;
int                                mdl_good_cnt;
bit                                mdl_lock;

function automatic void reset_model();
    mdl_scr_hist = '0;
    mdl_exp_q.delete();
    mdl_err_cnt  = '0;
    mdl_good_cnt = 0;
    mdl_lock     = 1'b0;
endfunction

// Input lane that lands on output lane k
function automatic int source_lane(input int k, input int rot);
    return (k + rot) % MDL_LANES;
endfunction

// Scrambles one block in output lane order
function automatic rx_line_pkg::payload_t scramble_block(input rx_line_pkg::payload_t plain);
    rx_line_pkg::payload_t line_word;
    for (int i = 0; i < $bits(plain); i++) begin
        line_word[i] = plain[i] ^ mdl_scr_hist[rx_line_pkg::SCR_TAP_B - rx_line_pkg::SCR_TAP_A]
                     ^ mdl_scr_hist[0];
        mdl_scr_hist = {line_word[i], mdl_scr_hist[rx_line_pkg::SCR_TAP_B-1:1]};
    end
    return line_word;
endfunction

// Shifts a raw line word into the history on bypass cycles
function automatic void absorb_line_word(input rx_line_pkg::payload_t line_word);
    for (int i = 0; i < $bits(line_word); i++) begin
        mdl_scr_hist = {line_word[i], mdl_scr_hist[rx_line_pkg::SCR_TAP_B-1:1]};
    end
endfunction

// Queues the decoded lane and bumps the count
function automatic void queue_expected(input rx_line_pkg::sync_hdr_t hdr,
                                       input rx_line_pkg::payload_t plain);
    xgmii_pkg::xgmii_lane_t exp_lane;
    bit                     err;
    err = 1'b0;
    if (hdr == rx_line_pkg::HDR_DATA) begin
        exp_lane = {8'h00, plain};
    end else if (hdr == rx_line_pkg::HDR_CTRL && plain[7:0] == xgmii_pkg::BLK_TYPE_IDLE) begin
        exp_lane = {8'hFF, {8{xgmii_pkg::XGMII_IDLE}}};
    end else begin
        exp_lane = {8'hFF, {8{xgmii_pkg::XGMII_ERROR}}};
        err      = 1'b1;
    end
    mdl_exp_q.push_back(exp_lane);
    if (err && mdl_err_cnt != 8'hFF) begin
        mdl_err_cnt = mdl_err_cnt + 8'd1;
    end
endfunction

function automatic void zero_model_count();
    mdl_err_cnt = '0;
endfunction

// One valid input cycle of the lock FSM
function automatic void step_lock_model(input bit all_good);
    if (!all_good) begin
        mdl_good_cnt = 0;
        mdl_lock     = 1'b0;
    end else if (!mdl_lock) begin
        mdl_good_cnt++;
        mdl_lock = (mdl_good_cnt >= rx_line_pkg::LOCK_GOOD_CNT);
    end
endfunction

`endif

// ==== tb/tb_pcs_rx.sv ====
// Testbench for the receive PCS top; drives random lanes and checks them against the included model
`timescale 1ns/1ps

module tb_pcs_rx;
    import rx_line_pkg::*;
    import xgmii_pkg::*;

    `include "pcs_rx_model.svh"

    localparam int N_DATA    = 200;
    localparam int N_CTRL    = 300;
    localparam int N_RESUME  = 40;
    localparam int N_ROT     = 120;
    localparam int N_LOCK    = 72;
    localparam int DRAIN_MAX = 6;
    // Reset and clear cycles, all phases, six drains and a margin
    localparam int TIMEOUT_CYCLES = 2 + N_DATA + N_CTRL + 2 + N_RESUME + N_ROT + N_LOCK
                                  + 6 * DRAIN_MAX + 50;

    localparam int MODE_DATA = 0;
    localparam int MODE_MIX  = 1;
    localparam int MODE_BAD1 = 2;

    logic                         rx_clk_161_13 = 1'b0;
    logic                         async_reset_n;
    logic                         rx_valid;
    sync_hdr_t                    rx_hdr [MDL_LANES];
    payload_t                     rx_data [MDL_LANES];
    logic [$clog2(MDL_LANES)-1:0] lane_rot;
    logic                         bypass_descram;
    logic                         clear_errblk;
    xgmii_lane_t                  xgmii [MDL_LANES];
    logic                         xgmii_valid;
    logic                         blk_lock;
    err_cnt_t                     errd_blks;

    integer   seed      = 46166;
    int       cycle_cnt = 0;
    bit       saw_lock  = 1'b0;
    string    test_name = "reset";
    err_cnt_t cnt_q [$];
    int       due_q [$];

    pcs_rx_top #(
        .num_lanes (MDL_LANES)
    ) DUT (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .rx_valid_i       (rx_valid),
        .rx_hdr_i         (rx_hdr),
        .rx_data_i        (rx_data),
        .lane_rot_i       (lane_rot),
        .bypass_descram_i (bypass_descram),
        .clear_errblk_i   (clear_errblk),
        .xgmii_o          (xgmii),
        .xgmii_valid_o    (xgmii_valid),
        .blk_lock_o       (blk_lock),
        .errd_blks_o      (errd_blks)
    );

    always #5 rx_clk_161_13 = ~rx_clk_161_13;

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string what, input logic [71:0] expected,
                               input logic [71:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // Header and plaintext of one lane
    task automatic pick_lane(input int mode, input bit force_bad, output sync_hdr_t hdr,
                             output payload_t plain);
        int kind;
        plain = {$random(seed), $random(seed)};
        kind  = (mode == MODE_MIX) ? {$random(seed)} % 4 : 0;
        if (force_bad) begin
            kind = 3;
        end
        case (kind)
            0: hdr = HDR_DATA;
            1: begin
                hdr        = HDR_CTRL;
                plain[7:0] = BLK_TYPE_IDLE;
            end
            2: begin
                hdr = HDR_CTRL;
                if (plain[7:0] == BLK_TYPE_IDLE) begin
                    plain[7:0] = 8'h78;
                end
            end
            default: hdr = ($random(seed) & 1) ? 2'b00 : 2'b11;
        endcase
    endtask

    // Checks lock from the last edge, then drives the next input cycle
    task automatic send_cycle(input bit valid, input int mode, input int rot, input bit bypass);
        sync_hdr_t hdr;
        payload_t  plain;
        int        bad_lane;
        int        src;
        bit        all_good;
        @(posedge rx_clk_161_13);
        #1;
        check_equal("block lock", 72'(mdl_lock), 72'(blk_lock));
        saw_lock       = saw_lock | blk_lock;
        rx_valid       = valid;
        lane_rot       = rot[$clog2(MDL_LANES)-1:0];
        bypass_descram = bypass;
        bad_lane       = {$random(seed)} % MDL_LANES;
        all_good       = 1'b1;
        for (int k = 0; k < MDL_LANES; k++) begin
            pick_lane(mode, (mode == MODE_BAD1) && (k == bad_lane), hdr, plain);
            src = valid ? source_lane(k, rot) : k;
            rx_hdr[src] = hdr;
            if (!valid) begin
                // Junk the DUT must ignore
                rx_data[src] = plain;
            end else if (bypass) begin
                rx_data[src] = plain;
                absorb_line_word(plain);
            end else begin
                rx_data[src] = scramble_block(plain);
            end
            if (valid) begin
                queue_expected(hdr, plain);
                all_good = all_good && (hdr == HDR_DATA || hdr == HDR_CTRL);
            end
        end
        if (valid) begin
            step_lock_model(all_good);
            cnt_q.push_back(mdl_err_cnt);
            // Decoder output lands three edges from now
            due_q.push_back(cycle_cnt + 3);
        end
    endtask

    // Bypass stays put until the descrambler has passed every block
    task automatic drain(input bit bypass);
        while (mdl_exp_q.size() != 0) begin
            send_cycle(1'b0, MODE_DATA, 0, bypass);
        end
    endtask

    task automatic clear_count();
        check_equal("count before clear", 72'(mdl_err_cnt), 72'(errd_blks));
        clear_errblk = 1'b1;
        send_cycle(1'b0, MODE_DATA, 0, 1'b0);
        send_cycle(1'b0, MODE_DATA, 0, 1'b0);
        check_equal("count while clear", 72'(0), 72'(errd_blks));
        clear_errblk = 1'b0;
        zero_model_count();
    endtask

    ////////////////////////////////////////
    // Output monitor and timeout
    ////////////////////////////////////////

    always @(negedge rx_clk_161_13) begin
        if (async_reset_n && xgmii_valid) begin
            if (mdl_exp_q.size() < MDL_LANES || cnt_q.size() == 0 || due_q.size() == 0) begin
                $display("XGMII output was valid while no block was expected");
                abort_run();
            end else begin
                check_equal("output cycle", 72'(due_q.pop_front()), 72'(cycle_cnt));
                for (int k = 0; k < MDL_LANES; k++) begin
                    check_equal($sformatf("xgmii lane %0d", k), mdl_exp_q.pop_front(), xgmii[k]);
                end
                check_equal("errored blocks", cnt_q.pop_front(), errd_blks);
            end
        end
    end

    always @(posedge rx_clk_161_13) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        async_reset_n  = 1'b0;
        rx_valid       = 1'b0;
        lane_rot       = '0;
        bypass_descram = 1'b0;
        clear_errblk   = 1'b0;
        for (int k = 0; k < MDL_LANES; k++) begin
            rx_hdr[k]  = '0;
            rx_data[k] = '0;
        end
        reset_model();
        repeat (2) @(posedge rx_clk_161_13);
        #1;
        async_reset_n = 1'b1;

        test_name = "data";
        for (int i = 0; i < N_DATA; i++) begin
            send_cycle(({$random(seed)} % 4) != 0, MODE_DATA, 0, 1'b0);
        end
        drain(1'b0);

        // Half the lanes error out, so the count saturates
        test_name = "control";
        for (int i = 0; i < N_CTRL; i++) begin
            send_cycle(({$random(seed)} % 8) != 0, MODE_MIX, 0, 1'b0);
        end
        drain(1'b0);

        test_name = "clear";
        clear_count();
        for (int i = 0; i < N_RESUME; i++) begin
            send_cycle(1'b1, MODE_MIX, 0, 1'b0);
        end
        drain(1'b0);

        test_name = "rotation";
        for (int i = 0; i < N_ROT / 2; i++) begin
            send_cycle(1'b1, MODE_DATA, {$random(seed)} % MDL_LANES, 1'b0);
        end
        drain(1'b0);

        test_name = "bypass";
        for (int i = 0; i < N_ROT / 2; i++) begin
            send_cycle(1'b1, MODE_DATA, {$random(seed)} % MDL_LANES, 1'b1);
        end
        drain(1'b1);

        // Bad header at both ends with enough good cycles between them to lock
        test_name = "lock";
        for (int i = 0; i < N_LOCK; i++) begin
            send_cycle(1'b1, (i == 0 || i == N_LOCK - 1) ? MODE_BAD1 : MODE_DATA,
                       {$random(seed)} % MDL_LANES, 1'b0);
        end
        drain(1'b0);

        if (!saw_lock || cnt_q.size() != 0) begin
            $display("Run ended with lock never seen or output counts left unchecked");
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== src/pcs_rx_top.sv ====
// Top of the four-lane 64b/66b receive PCS; chains capture, descrambler and decoder
`timescale 1ns/1ps

module pcs_rx_top #(
    parameter int num_lanes = rx_line_pkg::NUM_LANES_DEF
) (
    input  logic                         rx_clk_161_13,
    input  logic                         async_reset_n,
    input  logic                         rx_valid_i,
    input  rx_line_pkg::sync_hdr_t       rx_hdr_i [num_lanes],
    input  rx_line_pkg::payload_t        rx_data_i [num_lanes],
    input  logic [$clog2(num_lanes)-1:0] lane_rot_i,
    input  logic                         bypass_descram_i,
    input  logic                         clear_errblk_i,
    output xgmii_pkg::xgmii_lane_t       xgmii_o [num_lanes],
    output logic                         xgmii_valid_o,
    output logic                         blk_lock_o,
    output xgmii_pkg::err_cnt_t          errd_blks_o
);
    import rx_line_pkg::*;

    rx_block_t cap_blk [num_lanes];
    logic      cap_valid;
    rx_block_t dsc_blk [num_lanes];
    logic      dsc_valid;

    rx_lane_capture #(
        .num_lanes (num_lanes)
    ) u_capture (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .valid_i       (rx_valid_i),
        .hdr_i         (rx_hdr_i),
        .data_i        (rx_data_i),
        .lane_rot_i    (lane_rot_i),
        .blk_o         (cap_blk),
        .valid_o       (cap_valid),
        .blk_lock_o    (blk_lock_o)
    );

    rx_descrambler #(
        .num_lanes (num_lanes)
    ) u_descrambler (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .valid_i       (cap_valid),
        .blk_i         (cap_blk),
        .bypass_i      (bypass_descram_i),
        .blk_o         (dsc_blk),
        .valid_o       (dsc_valid)
    );

    rx_block_decoder #(
        .num_lanes (num_lanes)
    ) u_decoder (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .valid_i       (dsc_valid),
        .blk_i         (dsc_blk),
        .clear_i       (clear_errblk_i),
        .xgmii_o       (xgmii_o),
        .valid_o       (xgmii_valid_o),
        .errd_blks_o   (errd_blks_o)
    );

endmodule

// ==== src/rx_block_decoder.sv ====
// Receive PCS output stage; decodes blocks onto XGMII lanes and counts errored blocks
`timescale 1ns/1ps

module rx_block_decoder #(
    parameter int num_lanes = rx_line_pkg::NUM_LANES_DEF
) (
    input  logic                   rx_clk_161_13,
    input  logic                   async_reset_n,
    input  logic                   valid_i,
    input  rx_line_pkg::rx_block_t blk_i [num_lanes],
    input  logic                   clear_i,
    output xgmii_pkg::xgmii_lane_t xgmii_o [num_lanes],
    output logic                   valid_o,
    output xgmii_pkg::err_cnt_t    errd_blks_o
);
    import rx_line_pkg::*;
    import xgmii_pkg::*;

    typedef logic [$clog2(num_lanes+1)-1:0]                  lane_cnt_t;
    typedef logic [$bits(err_cnt_t)+$clog2(num_lanes+1)-1:0] cnt_sum_t;

    localparam err_cnt_t err_cnt_max = '1;

    xgmii_lane_t      dec_lane [num_lanes];
    logic [num_lanes-1:0] lane_err;
    lane_cnt_t        err_lanes;
    cnt_sum_t         cnt_sum;

    always_comb begin
        err_lanes = '0;
        for (int k = 0; k < num_lanes; k++) begin
            lane_err[k] = 1'b0;
            if (blk_i[k].hdr_ok && (blk_i[k].hdr == HDR_DATA)) begin
                dec_lane[k].ctrl = '0;
                dec_lane[k].data = blk_i[k].payload;
            end else if (blk_i[k].hdr_ok && (blk_i[k].payload[7:0] == BLK_TYPE_IDLE)) begin
                dec_lane[k].ctrl = '1;
                dec_lane[k].data = {8{XGMII_IDLE}};
            end else begin
                // Unknown type or bad header
                dec_lane[k].ctrl = '1;
                dec_lane[k].data = {8{XGMII_ERROR}};
                lane_err[k]      = 1'b1;
            end
            err_lanes = err_lanes + lane_cnt_t'(lane_err[k]);
        end
    end

    assign cnt_sum = cnt_sum_t'(errd_blks_o) + cnt_sum_t'(err_lanes);

    always_ff @(posedge rx_clk_161_13) begin
        if (valid_i) begin
            xgmii_o <= dec_lane;
        end
    end

    ////////////////////////////////////////
    // Errored block counter
    ////////////////////////////////////////

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            valid_o     <= 1'b0;
            errd_blks_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (clear_i) begin
                errd_blks_o <= '0;
            end else if (valid_i) begin
                // Saturate at full scale
                if (cnt_sum > cnt_sum_t'(err_cnt_max)) begin
                    errd_blks_o <= err_cnt_max;
                end else begin
                    errd_blks_o <= err_cnt_t'(cnt_sum);
                end
            end
        end
    end

endmodule

// ==== src/rx_descrambler.sv ====
// Receive PCS descrambler; self-synchronizing x^58 + x^39 + 1 chained across all lanes
`timescale 1ns/1ps

module rx_descrambler #(
    parameter int num_lanes = rx_line_pkg::NUM_LANES_DEF
) (
    input  logic                   rx_clk_161_13,
    input  logic                   async_reset_n,
    input  logic                   valid_i,
    input  rx_line_pkg::rx_block_t blk_i [num_lanes],
    input  logic                   bypass_i,
    output rx_line_pkg::rx_block_t blk_o [num_lanes],
    output logic                   valid_o
);
    import rx_line_pkg::*;

    localparam int payload_w = $bits(payload_t);
    localparam int stream_w  = num_lanes * payload_w;
    localparam int hist_w    = SCR_TAP_B;

    logic [stream_w-1:0]        cur_stream;
    logic [stream_w+hist_w-1:0] ext_stream;
    logic [stream_w-1:0]        plain_stream;
    logic [hist_w-1:0]          scr_hist;

    // Lane 0 bit 0 first, last lane bit 63 last
    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            cur_stream[k*payload_w +: payload_w] = blk_i[k].payload;
        end
    end

    // Last cycle's tail sits below the current bits
    assign ext_stream = {cur_stream, scr_hist};

    always_comb begin
        for (int i = 0; i < stream_w; i++) begin
            plain_stream[i] = ext_stream[i + hist_w]
                            ^ ext_stream[i + hist_w - SCR_TAP_A]
                            ^ ext_stream[i + hist_w - SCR_TAP_B];
        end
    end

    ////////////////////////////////////////
    // History and output registers
    ////////////////////////////////////////

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            valid_o  <= 1'b0;
            scr_hist <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                // Scrambled tail feeds next cycle's lane 0 even in bypass
                scr_hist <= cur_stream[stream_w-1 -: hist_w];
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (valid_i) begin
            for (int k = 0; k < num_lanes; k++) begin
                blk_o[k].hdr     <= blk_i[k].hdr;
                blk_o[k].hdr_ok  <= blk_i[k].hdr_ok;
                blk_o[k].payload <= bypass_i ? blk_i[k].payload
                                             : plain_stream[k*payload_w +: payload_w];
            end
        end
    end

endmodule

// ==== src/rx_lane_capture.sv ====
// Receive PCS input stage; registers and rotates the lanes, checks headers, tracks block lock
`timescale 1ns/1ps

module rx_lane_capture #(
    parameter int num_lanes = rx_line_pkg::NUM_LANES_DEF
) (
    input  logic                         rx_clk_161_13,
    input  logic                         async_reset_n,
    input  logic                         valid_i,
    input  rx_line_pkg::sync_hdr_t       hdr_i [num_lanes],
    input  rx_line_pkg::payload_t        data_i [num_lanes],
    input  logic [$clog2(num_lanes)-1:0] lane_rot_i,
    output rx_line_pkg::rx_block_t       blk_o [num_lanes],
    output logic                         valid_o,
    output logic                         blk_lock_o
);
    import rx_line_pkg::*;

    typedef enum logic {
        LOCK_HUNT,
        LOCKED
    } lock_state_t;

    typedef logic [$clog2(LOCK_GOOD_CNT):0] lock_cnt_t;

    lock_state_t lock_state;
    lock_cnt_t   good_cnt;
    rx_block_t   rot_blk [num_lanes];
    logic        all_good;

    // Output lane k takes input lane (k + rot) mod num_lanes
    always_comb begin
        int src;
        all_good = 1'b1;
        for (int k = 0; k < num_lanes; k++) begin
            src = (k + int'(lane_rot_i)) % num_lanes;
            rot_blk[k].hdr     = hdr_i[src];
            rot_blk[k].payload = data_i[src];
            rot_blk[k].hdr_ok  = (hdr_i[src] == HDR_DATA) || (hdr_i[src] == HDR_CTRL);
            all_good           = all_good & rot_blk[k].hdr_ok;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (valid_i) begin
            blk_o <= rot_blk;
        end
    end

    ////////////////////////////////////////
    // Block lock FSM
    ////////////////////////////////////////

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            valid_o    <= 1'b0;
            lock_state <= LOCK_HUNT;
            good_cnt   <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                if (!all_good) begin
                    // One bad header drops lock
                    lock_state <= LOCK_HUNT;
                    good_cnt   <= '0;
                end else if (lock_state == LOCK_HUNT) begin
                    if (good_cnt == lock_cnt_t'(LOCK_GOOD_CNT - 1)) begin
                        lock_state <= LOCKED;
                    end
                    good_cnt <= good_cnt + 1'b1;
                end
            end
        end
    end

    assign blk_lock_o = (lock_state == LOCKED);

endmodule

// ==== src/xgmii_pkg.sv ====
// XGMII character codes, block type codes and lane format used by the receive decoder
package xgmii_pkg;

    typedef logic [7:0] xgmii_char_t;

    // One 64-bit XGMII lane where ctrl bit n flags data byte n
    typedef struct packed {
        logic [7:0]  ctrl;
        logic [63:0] data;
    } xgmii_lane_t;

    ////////////////////////////////////////
    // Character and block type codes
    ////////////////////////////////////////

    localparam xgmii_char_t XGMII_IDLE  = 8'h07;
    localparam xgmii_char_t XGMII_ERROR = 8'hFE;

    // Block type byte sits in payload bits 7:0
    localparam xgmii_char_t BLK_TYPE_IDLE = 8'h1E;

    // Saturating errored-block count
    typedef logic [7:0] err_cnt_t;

endpackage

// ==== src/rx_line_pkg.sv ====
// Line-side widths, block format and constants shared by the receive PCS stages
package rx_line_pkg;

    ////////////////////////////////////////
    // 66-bit block format
    ////////////////////////////////////////

    // Payload of one 64b/66b block with bit 0 first on the line
    typedef logic [63:0] payload_t;

    typedef logic [1:0] sync_hdr_t;

    // hdr_ok is decided at capture and trusted downstream
    typedef struct packed {
        sync_hdr_t hdr;
        payload_t  payload;
        logic      hdr_ok;
    } rx_block_t;

    ////////////////////////////////////////
    // Lane and lock settings
    ////////////////////////////////////////

    localparam int NUM_LANES_DEF = 4;

    // Sync header codes
    localparam sync_hdr_t HDR_DATA = 2'b01;
    localparam sync_hdr_t HDR_CTRL = 2'b10;

    // Consecutive all-good cycles before lock
    localparam int LOCK_GOOD_CNT = 64;

    ////////////////////////////////////////
    // Descrambler polynomial x^58 + x^39 + 1
    ////////////////////////////////////////

    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

endpackage
